/* source/duck_game_pkg.sv */
package duck_game_pkg;

    //--------------------------------------------------------------------------
    // geometry
    //--------------------------------------------------------------------------

    // every x and y coordinate on screen
    localparam int coord_w = 12;

    //--------------------------------------------------------------------------
    // game phases
    //--------------------------------------------------------------------------

    typedef enum logic [2:0] {
        phase_idle      = 3'd0,
        phase_countdown = 3'd1,
        phase_hunting   = 3'd2,
        phase_reloading = 3'd3,
        phase_falling   = 3'd4
    } game_phase_t;

    //--------------------------------------------------------------------------
    // ammunition and score
    //--------------------------------------------------------------------------

    // rounds in a full magazine
    localparam int magazine_size = 3;
    // rounds handed out at game start
    localparam int total_rounds = 30;

    // magazine count
    localparam int mag_w = 3;
    // all rounds left, magazine included
    localparam int reserve_w = 6;
    // kills so far
    localparam int score_w = 7;

endpackage

/* source/mouse_event_decode.sv */
`timescale 1ns/1ps

module mouse_event_decode #(
    parameter int duck_width  = 96,
    parameter int duck_height = 60
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [duck_game_pkg::coord_w-1:0] mouse_xpos,
    input  logic [duck_game_pkg::coord_w-1:0] mouse_ypos,
    input  logic [duck_game_pkg::coord_w-1:0] duck_xpos,
    input  logic [duck_game_pkg::coord_w-1:0] duck_ypos,
    input  logic                              left_mouse,
    input  logic                              right_mouse,
    output logic                              shot,
    output logic                              hit,
    output logic                              reload_req
);

    import duck_game_pkg::*;

    // button levels from the previous edge
    logic left_prev;
    logic right_prev;
    logic left_rise;
    logic right_rise;

    // far corner of the duck box, one bit wider so it cannot wrap
    logic [coord_w:0] box_right;
    logic [coord_w:0] box_bottom;
    logic             in_box_x;
    logic             in_box_y;

    assign left_rise  = left_mouse & ~left_prev;
    assign right_rise = right_mouse & ~right_prev;

    //--------------------------------------------------------------------------
    // hit test, inclusive on all four edges
    //--------------------------------------------------------------------------

    assign box_right  = {1'b0, duck_xpos} + (coord_w + 1)'(duck_width);
    assign box_bottom = {1'b0, duck_ypos} + (coord_w + 1)'(duck_height);

    assign in_box_x = (mouse_xpos >= duck_xpos) && ({1'b0, mouse_xpos} <= box_right);
    assign in_box_y = (mouse_ypos >= duck_ypos) && ({1'b0, mouse_ypos} <= box_bottom);

    //--------------------------------------------------------------------------
    // event pulses
    //--------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            left_prev  <= 1'b0;
            right_prev <= 1'b0;
            shot       <= 1'b0;
            hit        <= 1'b0;
            reload_req <= 1'b0;
        end else begin
            left_prev  <= left_mouse;
            right_prev <= right_mouse;
            // one pulse per press, however long the button is held
            shot       <= left_rise;
            // hit only means something together with shot
            hit        <= left_rise & in_box_x & in_box_y;
            reload_req <= right_rise;
        end
    end

endmodule

/* source/game_sequencer.sv */
`timescale 1ns/1ps

module game_sequencer #(
    parameter int countdown_cycles = 40,
    parameter int fall_cycles      = 20,
    parameter int reload_cycles    = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       game_enable,
    input  logic                       reload_req,
    input  logic                       kill,
    output duck_game_pkg::game_phase_t phase,
    output logic                       hunt_start
);

    import duck_game_pkg::*;

    // the delay timer must hold the longest phase minus one
    localparam int longest_a = (countdown_cycles > fall_cycles) ? countdown_cycles : fall_cycles;
    localparam int longest   = (longest_a > reload_cycles) ? longest_a : reload_cycles;
    localparam int timer_w   = (longest > 1) ? $clog2(longest) : 1;

    game_phase_t        phase_nxt;
    logic [timer_w-1:0] delay;
    logic [timer_w-1:0] delay_nxt;
    logic               delay_done;

    assign delay_done = (delay == '0);

    //--------------------------------------------------------------------------
    // next phase and delay timer
    //--------------------------------------------------------------------------

    always_comb begin
        phase_nxt = phase;
        delay_nxt = delay;
        case (phase)
            phase_idle: begin
                if (game_enable) begin
                    phase_nxt = phase_countdown;
                    delay_nxt = timer_w'(countdown_cycles - 1);
                end
            end
            // all three timed phases end back in hunting
            phase_countdown, phase_reloading, phase_falling: begin
                if (delay_done) begin
                    phase_nxt = phase_hunting;
                end else begin
                    delay_nxt = delay - timer_w'(1);
                end
            end
            phase_hunting: begin
                // a kill wins over a reload in the same cycle
                if (kill) begin
                    phase_nxt = phase_falling;
                    delay_nxt = timer_w'(fall_cycles - 1);
                end else if (reload_req) begin
                    phase_nxt = phase_reloading;
                    delay_nxt = timer_w'(reload_cycles - 1);
                end
            end
            default: begin
                phase_nxt = phase_idle;
                delay_nxt = '0;
            end
        endcase
    end

    //--------------------------------------------------------------------------
    // phase register
    //--------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phase_idle;
            delay <= '0;
        end else begin
            phase <= phase_nxt;
            delay <= delay_nxt;
        end
    end

    // straight from the phase register
    assign hunt_start = (phase == phase_hunting);

endmodule

/* source/ammo_score_keeper.sv */
`timescale 1ns/1ps

module ammo_score_keeper (
    input  logic                                clk,
    input  logic                                rst,
    input  duck_game_pkg::game_phase_t          phase,
    input  logic                                shot,
    input  logic                                hit,
    output logic [duck_game_pkg::mag_w-1:0]     bullets_in_magazine,
    output logic [duck_game_pkg::reserve_w-1:0] bullets_left,
    output logic [duck_game_pkg::score_w-1:0]   my_score,
    output logic                                show_reload_char,
    output logic                                kill,
    output logic                                game_over
);

    import duck_game_pkg::*;

    // own copy of the phase, for entry detection
    game_phase_t      phase_prev;
    logic             game_start;
    logic             reload_entry;
    logic             hunt_shot;
    logic             mag_empty;
    logic [mag_w-1:0] refill;

    assign game_start   = (phase_prev == phase_idle) && (phase != phase_idle);
    assign reload_entry = (phase == phase_reloading) && (phase_prev != phase_reloading);

    // shots outside hunting are dropped
    assign hunt_shot = shot && (phase == phase_hunting);
    assign mag_empty = (bullets_in_magazine == '0);

    // a hit only counts with a round in the magazine
    assign kill = hunt_shot && hit && !mag_empty;

    // smaller of a full magazine and what is left
    assign refill = (bullets_left < reserve_w'(magazine_size)) ? mag_w'(bullets_left)
                                                               : mag_w'(magazine_size);

    // counts are not loaded yet on the first countdown cycle
    assign game_over = (bullets_left == '0) && (phase != phase_idle) && !game_start;

    //--------------------------------------------------------------------------
    // counts
    //--------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_prev          <= phase_idle;
            bullets_in_magazine <= '0;
            bullets_left        <= '0;
            my_score            <= '0;
            show_reload_char    <= 1'b0;
        end else begin
            phase_prev <= phase;
            if (game_start) begin
                bullets_in_magazine <= mag_w'(magazine_size);
                bullets_left        <= reserve_w'(total_rounds);
                my_score            <= '0;
                show_reload_char    <= 1'b0;
            end else if (reload_entry) begin
                // reserve already counts the magazine, so it stays
                bullets_in_magazine <= refill;
                show_reload_char    <= 1'b0;
            end else if (hunt_shot) begin
                if (mag_empty) begin
                    show_reload_char <= 1'b1;
                end else begin
                    bullets_in_magazine <= bullets_in_magazine - mag_w'(1);
                    bullets_left        <= bullets_left - reserve_w'(1);
                    if (kill) begin
                        my_score <= my_score + score_w'(1);
                    end
                end
            end
        end
    end

endmodule

/* source/duck_flight.sv */
`timescale 1ns/1ps

module duck_flight #(
    parameter int field_width  = 1024,
    parameter int field_height = 768,
    parameter int duck_width   = 96,
    parameter int duck_height  = 60,
    parameter int move_period  = 650_000
) (
    input  logic                              clk,
    input  logic                              rst,
    input  duck_game_pkg::game_phase_t        phase,
    input  logic                              kill,
    output logic [duck_game_pkg::coord_w-1:0] duck_xpos,
    output logic [duck_game_pkg::coord_w-1:0] duck_ypos
);

    import duck_game_pkg::*;

    // corner limits keeping the whole box on the field
    localparam int x_span = field_width - duck_width;
    localparam int y_span = field_height - duck_height;
    localparam int step_w = (move_period > 1) ? $clog2(move_period) : 1;

    localparam logic [coord_w-1:0] x_max = coord_w'(x_span);
    localparam logic [coord_w-1:0] y_max = coord_w'(y_span);

    logic [step_w-1:0]  step_cnt;
    logic               step;
    logic               going_right;
    logic               going_up;
    logic [15:0]        lfsr;
    logic               lfsr_fb;
    logic [coord_w-1:0] spawn_x;

    // taps 16 14 13 11, maximal length
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign spawn_x = coord_w'(lfsr % (x_span + 1));

    assign step = (phase == phase_hunting) && (step_cnt == step_w'(move_period - 1));

    //--------------------------------------------------------------------------
    // position and direction
    //--------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            duck_xpos   <= coord_w'(x_span / 2);
            duck_ypos   <= y_max;
            going_right <= 1'b1;
            going_up    <= 1'b1;
            step_cnt    <= '0;
            lfsr        <= 16'hace1;
        end else begin
            // sequence runs every cycle so spawns depend on click timing
            lfsr <= {lfsr[14:0], lfsr_fb};
            if (phase != phase_hunting || step) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + step_w'(1);
            end
            if (kill) begin
                // fresh duck rises from the bottom
                duck_xpos   <= spawn_x;
                duck_ypos   <= y_max;
                going_up    <= 1'b1;
                going_right <= lfsr[0];
            end else if (step) begin
                // horizontal bounce
                if (going_right) begin
                    if (duck_xpos >= x_max) begin
                        going_right <= 1'b0;
                        duck_xpos   <= duck_xpos - coord_w'(1);
                    end else begin
                        duck_xpos <= duck_xpos + coord_w'(1);
                    end
                end else if (duck_xpos == '0) begin
                    going_right <= 1'b1;
                    duck_xpos   <= duck_xpos + coord_w'(1);
                end else begin
                    duck_xpos <= duck_xpos - coord_w'(1);
                end
                // vertical bounce, up is smaller y
                if (going_up) begin
                    if (duck_ypos == '0) begin
                        going_up  <= 1'b0;
                        duck_ypos <= duck_ypos + coord_w'(1);
                    end else begin
                        duck_ypos <= duck_ypos - coord_w'(1);
                    end
                end else if (duck_ypos >= y_max) begin
                    going_up  <= 1'b1;
                    duck_ypos <= duck_ypos - coord_w'(1);
                end else begin
                    duck_ypos <= duck_ypos + coord_w'(1);
                end
            end
        end
    end

endmodule

/* source/duck_game_core.sv */
`timescale 1ns/1ps

module duck_game_core #(
    parameter int duck_width       = 96,
    parameter int duck_height      = 60,
    // timers in cycles, about 4 s, 2 s and 0.1 s at 65 MHz
    parameter int countdown_cycles = 260_000_000,
    parameter int fall_cycles      = 130_000_000,
    parameter int reload_cycles    = 6_500_000,
    parameter int field_width      = 1024,
    parameter int field_height     = 768,
    // one pixel step every 10 ms
    parameter int move_period      = 650_000
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [duck_game_pkg::coord_w-1:0]   mouse_xpos,
    input  logic [duck_game_pkg::coord_w-1:0]   mouse_ypos,
    input  logic                                left_mouse,
    input  logic                                right_mouse,
    input  logic                                game_enable,
    output logic [duck_game_pkg::coord_w-1:0]   duck_xpos,
    output logic [duck_game_pkg::coord_w-1:0]   duck_ypos,
    output logic [duck_game_pkg::mag_w-1:0]     bullets_in_magazine,
    output logic [duck_game_pkg::reserve_w-1:0] bullets_left,
    output logic [duck_game_pkg::score_w-1:0]   my_score,
    output logic                                hunt_start,
    output logic                                show_reload_char,
    output logic                                game_over
);

    import duck_game_pkg::*;

    // events from the decode block
    logic        shot;
    logic        hit;
    logic        reload_req;
    // phase and kill feedback
    game_phase_t phase;
    logic        kill;

    //--------------------------------------------------------------------------
    // decode, sequence, count, fly
    //--------------------------------------------------------------------------

    mouse_event_decode #(
        .duck_width  (duck_width),
        .duck_height (duck_height)
    ) u_decode (
        .clk         (clk),
        .rst         (rst),
        .mouse_xpos  (mouse_xpos),
        .mouse_ypos  (mouse_ypos),
        .duck_xpos   (duck_xpos),
        .duck_ypos   (duck_ypos),
        .left_mouse  (left_mouse),
        .right_mouse (right_mouse),
        .shot        (shot),
        .hit         (hit),
        .reload_req  (reload_req)
    );

    game_sequencer #(
        .countdown_cycles (countdown_cycles),
        .fall_cycles      (fall_cycles),
        .reload_cycles    (reload_cycles)
    ) u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .game_enable (game_enable),
        .reload_req  (reload_req),
        .kill        (kill),
        .phase       (phase),
        .hunt_start  (hunt_start)
    );

    ammo_score_keeper u_keeper (
        .clk                 (clk),
        .rst                 (rst),
        .phase               (phase),
        .shot                (shot),
        .hit                 (hit),
        .bullets_in_magazine (bullets_in_magazine),
        .bullets_left        (bullets_left),
        .my_score            (my_score),
        .show_reload_char    (show_reload_char),
        .kill                (kill),
        .game_over           (game_over)
    );

    duck_flight #(
        .field_width  (field_width),
        .field_height (field_height),
        .duck_width   (duck_width),
        .duck_height  (duck_height),
        .move_period  (move_period)
    ) u_flight (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .kill      (kill),
        .duck_xpos (duck_xpos),
        .duck_ypos (duck_ypos)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst
);

    // free running, 40 ns period by default
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, away from the DUT edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* test/duck_game_tb.sv */
`timescale 1ns/1ps

module duck_game_tb;

    import duck_game_pkg::*;

    localparam int duck_width       = 96;
    localparam int duck_height      = 60;
    localparam int field_width      = 1024;
    localparam int field_height     = 768;
    // short timers, a whole game fits in a few thousand cycles
    localparam int countdown_cycles = 8;
    localparam int fall_cycles      = 6;
    localparam int reload_cycles    = 4;
    localparam int move_period      = 5;
    localparam int wait_limit       = 100;
    localparam int max_moves        = 400;
    // expected counts packed as magazine, reserve, score
    localparam int count_w          = mag_w + reserve_w + score_w;

    logic                 clk;
    logic                 rst;
    logic [coord_w-1:0]   mouse_xpos;
    logic [coord_w-1:0]   mouse_ypos;
    logic                 left_mouse;
    logic                 right_mouse;
    logic                 game_enable;
    logic [coord_w-1:0]   duck_xpos;
    logic [coord_w-1:0]   duck_ypos;
    logic [mag_w-1:0]     bullets_in_magazine;
    logic [reserve_w-1:0] bullets_left;
    logic [score_w-1:0]   my_score;
    logic                 hunt_start;
    logic                 show_reload_char;
    logic                 game_over;

    // shadow of the game state
    int   sh_mag;
    int   sh_res;
    int   sh_score;
    logic sh_reload;

    // pending shot checks, due on a cycle count
    int                 cycle_cnt = 0;
    int                 due_q[$];
    logic [count_w-1:0] exp_q[$];
    logic               exp_reload_q[$];

    int   moves;
    int   pick;
    int   rx;
    int   ry;
    int   old_x;
    int   old_y;
    logic killed;

    tb_clock_gen #(
        .half_period  (20),
        .reset_cycles (16)
    ) clock0 (
        .clk (clk),
        .rst (rst)
    );

    duck_game_core #(
        .duck_width       (duck_width),
        .duck_height      (duck_height),
        .countdown_cycles (countdown_cycles),
        .fall_cycles      (fall_cycles),
        .reload_cycles    (reload_cycles),
        .field_width      (field_width),
        .field_height     (field_height),
        .move_period      (move_period)
    ) dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .mouse_xpos          (mouse_xpos),
        .mouse_ypos          (mouse_ypos),
        .left_mouse          (left_mouse),
        .right_mouse         (right_mouse),
        .game_enable         (game_enable),
        .duck_xpos           (duck_xpos),
        .duck_ypos           (duck_ypos),
        .bullets_in_magazine (bullets_in_magazine),
        .bullets_left        (bullets_left),
        .my_score            (my_score),
        .hunt_start          (hunt_start),
        .show_reload_char    (show_reload_char),
        .game_over           (game_over)
    );

    //--------------------------------------------------------------------------
    // reference model and checks
    //--------------------------------------------------------------------------

    // counts after one left click, from the game rules
    function automatic logic [count_w-1:0] expected_counts(
        input int mag, input int res, input int score, input logic hunting,
        input int mx, input int my, input int dx, input int dy);
        int   n_mag;
        int   n_res;
        int   n_score;
        logic in_box;
        n_mag   = mag;
        n_res   = res;
        n_score = score;
        // box edges inclusive
        in_box = (mx >= dx) && (mx <= dx + duck_width) && (my >= dy) && (my <= dy + duck_height);
        if (hunting && mag > 0) begin
            n_mag = mag - 1;
            n_res = res - 1;
            if (in_box) begin
                n_score = score + 1;
            end
        end
        return {n_mag[mag_w-1:0], n_res[reserve_w-1:0], n_score[score_w-1:0]};
    endfunction

    // x clear of the box, on whichever side has room
    function automatic int miss_x(input int dx);
        if (dx + duck_width + 40 < field_width) begin
            return dx + duck_width + 40;
        end
        return dx - 40;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // counters settle two edges after the press
    always @(negedge clk) begin : compare_shots
        logic [count_w-1:0] exp_counts;
        logic               exp_reload;
        while (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
            due_q.delete(0);
            exp_counts = exp_q.pop_front();
            exp_reload = exp_reload_q.pop_front();
            check_value("bullets_in_magazine", bullets_in_magazine,
                        exp_counts[count_w-1 -: mag_w]);
            check_value("bullets_left", bullets_left,
                        exp_counts[reserve_w+score_w-1 -: reserve_w]);
            check_value("my_score", my_score, exp_counts[score_w-1:0]);
            check_value("show_reload_char", show_reload_char, exp_reload);
            // out of rounds once the reserve is used up
            check_value("game_over", game_over,
                        exp_counts[reserve_w+score_w-1 -: reserve_w] == '0);
        end
    end

    //--------------------------------------------------------------------------
    // stimulus helpers, all entered on a falling edge
    //--------------------------------------------------------------------------

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: reset was never released");
                $display("Checks failed");
                $fatal(1);
            end
        end
        @(negedge clk);
    endtask

    task automatic wait_hunt(input logic level, input string what);
        int waited;
        waited = 0;
        while (hunt_start !== level) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: hunt_start did not go to %0d during %s", level, what);
                $display("Checks failed");
                $fatal(1);
            end
        end
    endtask

    task automatic wait_game_over();
        int waited;
        waited = 0;
        while (game_over !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                $display("timeout: game_over did not rise after the last round");
                $display("Checks failed");
                $fatal(1);
            end
        end
    endtask

    // one left click, expected counts queued for the compare process
    task automatic fire_shot(input int mx, input int my, output logic kill_seen);
        logic [count_w-1:0] exp_counts;
        mouse_xpos = coord_w'(mx);
        mouse_ypos = coord_w'(my);
        left_mouse = 1'b1;
        exp_counts = expected_counts(sh_mag, sh_res, sh_score, hunt_start, mx, my,
                                     duck_xpos, duck_ypos);
        // empty magazine only raises the hint
        if (hunt_start && sh_mag == 0) begin
            sh_reload = 1'b1;
        end
        kill_seen = (exp_counts[score_w-1:0] != sh_score[score_w-1:0]);
        sh_mag    = exp_counts[count_w-1 -: mag_w];
        sh_res    = exp_counts[reserve_w+score_w-1 -: reserve_w];
        sh_score  = exp_counts[score_w-1:0];
        due_q.push_back(cycle_cnt + 2);
        exp_q.push_back(exp_counts);
        exp_reload_q.push_back(sh_reload);
        @(negedge clk);
        left_mouse = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // right click, then the whole reload pause
    task automatic do_reload();
        right_mouse = 1'b1;
        @(negedge clk);
        right_mouse = 1'b0;
        wait_hunt(1'b0, "the reload pause start");
        wait_hunt(1'b1, "the reload pause end");
        sh_mag    = (sh_res < magazine_size) ? sh_res : magazine_size;
        sh_reload = 1'b0;
        check_value("bullets_in_magazine", bullets_in_magazine, sh_mag);
        check_value("bullets_left", bullets_left, sh_res);
        check_value("show_reload_char", show_reload_char, 1'b0);
    endtask

    //--------------------------------------------------------------------------
    // main sequence
    //--------------------------------------------------------------------------

    initial begin
        // seed the generator once
        pick        = $urandom(32'h189b);
        mouse_xpos  = '0;
        mouse_ypos  = '0;
        left_mouse  = 1'b0;
        right_mouse = 1'b0;
        game_enable = 1'b0;
        sh_mag      = 0;
        sh_res      = 0;
        sh_score    = 0;
        sh_reload   = 1'b0;
        wait_reset_release();

        // everything cleared by reset
        check_value("bullets_in_magazine", bullets_in_magazine, 0);
        check_value("bullets_left", bullets_left, 0);
        check_value("my_score", my_score, 0);
        check_value("hunt_start", hunt_start, 0);
        check_value("show_reload_char", show_reload_char, 0);
        check_value("game_over", game_over, 0);

        // game start loads the counts
        game_enable = 1'b1;
        wait_hunt(1'b1, "the start countdown");
        sh_mag   = magazine_size;
        sh_res   = total_rounds;
        sh_score = 0;
        check_value("bullets_in_magazine", bullets_in_magazine, sh_mag);
        check_value("bullets_left", bullets_left, sh_res);
        check_value("my_score", my_score, sh_score);

        // a miss
        fire_shot(miss_x(duck_xpos), duck_ypos, killed);

        // a hit in the box centre, duck falls and respawns
        old_x = duck_xpos;
        old_y = duck_ypos;
        fire_shot(duck_xpos + duck_width / 2, duck_ypos + duck_height / 2, killed);
        wait_hunt(1'b0, "the duck fall start");
        wait_hunt(1'b1, "the duck fall end");
        check_value("duck position changed", (duck_xpos != old_x) || (duck_ypos != old_y), 1);

        // empty the magazine, one more click only raises the hint
        while (sh_mag > 0) begin
            fire_shot(miss_x(duck_xpos), duck_ypos, killed);
        end
        fire_shot(miss_x(duck_xpos), duck_ypos, killed);
        do_reload();

        // random play until the rounds run out
        moves = 0;
        while (sh_res > 0) begin
            moves++;
            if (moves > max_moves) begin
                $display("random play did not use up the rounds in %0d moves", max_moves);
                $display("Checks failed");
                $fatal(1);
            end
            pick = $urandom % 8;
            if (pick < 2) begin
                do_reload();
            end else begin
                if (pick < 5) begin
                    rx = duck_xpos + $urandom % (duck_width + 1);
                    ry = duck_ypos + $urandom % (duck_height + 1);
                end else begin
                    rx = $urandom % field_width;
                    ry = $urandom % field_height;
                end
                fire_shot(rx, ry, killed);
                if (killed) begin
                    wait_hunt(1'b0, "a random fall start");
                    wait_hunt(1'b1, "a random fall end");
                end
            end
        end

        wait_game_over();
        $display("All checks passed");
        $finish;
    end

endmodule

/* filelist.f */
source/duck_game_pkg.sv
source/mouse_event_decode.sv
source/game_sequencer.sv
source/ammo_score_keeper.sv
source/duck_flight.sv
source/duck_game_core.sv
test/tb_clock_gen.sv
test/duck_game_tb.sv
